// ==== bench/replay_play_tests.txt ====
// base size maxlen halt ncmd cmd0 cmd1 cmd2 cmd3 expected_words
// with halt set, cmd0 is halted and the later commands are counted in expected_words
00001000 00000100 00000006 0 1 80000028 00000000 00000000 00000000 00000028
00002000 00000400 00000005 0 3 C0000014 C0000007 10000000 00000000 0000001B
00003000 00000080 00000010 1 2 E000000A 80000004 00000000 00000000 00000004
00004000 00000200 00000010 0 2 00000008 80000008 00000000 00000000 00000008
00005000 00000800 00000007 0 1 800000C8 00000000 00000000 00000000 000000C8
00006000 00000068 00000003 0 2 C0000011 80000009 00000000 00000000 0000001A

// ==== replay_play.f ====
+incdir+source
source/replay_pkg.sv
source/replay_regs.sv
source/replay_cmd_fifo.sv
source/replay_play_fsm.sv
source/replay_tlast_gen.sv
source/replay_out_fifo.sv
source/replay_play.sv
bench/replay_play_checker.sv
bench/replay_play_props.sv
bench/replay_play_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal
TOP       := replay_play_tb
FILELIST  := replay_play.f
OBJDIR    := obj_dir
BIN       := $(OBJDIR)/V$(TOP)
SOURCES   := $(wildcard source/*.sv source/*.svh bench/*.sv)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; \
	echo "$$out" | grep -q "^TEST RESULT: PASS$$"

clean:
	rm -rf $(OBJDIR)

// ==== bench/replay_play_tb.sv ====
// Replay playback testbench
// Clock, reset, DMA memory model and settings traffic taken from the test table
`timescale 1ns/1ps
`default_nettype none
`include "replay_settings.svh"

module replay_play_tb import replay_pkg::*; ();

  localparam int NUM_TESTS  = 6;
  localparam int COLS       = 10;
  localparam int WORD_LIMIT = 20000;
  localparam int SETTLE     = 300;

  logic        clk;
  logic        rst;
  set_bus_t    set;
  logic [7:0]  rb_addr;
  logic [31:0] rb_data;
  dma_req_t    read_req;
  logic        read_ctrl_valid;
  logic        read_ctrl_ready = 1'b1;
  logic [63:0] read_data       = '0;
  logic        read_data_valid = 1'b0;
  logic        read_data_ready;
  beat_t       out;
  logic        out_valid;
  logic        out_ready       = 1'b0;

  logic [31:0] tests [NUM_TESTS*COLS];
  logic [15:0] lfsr = 16'd38;
  int          timeouts;
  // Memory model state
  int          mstate = 0;
  logic [31:0] maddr;
  int          mleft;
  int          mdelay;

  replay_play replay_play_i (
    .clk, .rst, .i_set (set), .i_rb_addr (rb_addr), .o_rb_data (rb_data),
    .o_read_req (read_req), .o_read_ctrl_valid (read_ctrl_valid),
    .i_read_ctrl_ready (read_ctrl_ready), .i_read_data (read_data),
    .i_read_data_valid (read_data_valid), .o_read_data_ready (read_data_ready),
    .o_out (out), .o_out_valid (out_valid), .i_out_ready (out_ready)
  );

  replay_play_checker checker_i (
    .clk, .rst, .i_out (out), .i_out_valid (out_valid),
    .i_out_ready (out_ready), .i_rb_data (rb_data)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Galois LFSR stepped once per bit taken
  function automatic int random_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      v    = (v << 1) | int'(lfsr[0]);
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
    end
    return v;
  endfunction

  // ------------------------------------------------------------
  // DMA memory model returning each word as its byte address
  // ------------------------------------------------------------
  always @(posedge clk) begin
    logic     req_seen;
    logic     data_taken;
    dma_req_t req;
    req_seen   = read_ctrl_valid && read_ctrl_ready;
    data_taken = read_data_valid && read_data_ready;
    req        = read_req;
    #1;
    if (rst) begin
      mstate          = 0;
      read_ctrl_ready = 1'b1;
      read_data_valid = 1'b0;
    end else begin
      case (mstate)
        0: if (req_seen) begin
          maddr  = req.addr;
          mleft  = int'(req.count) + 1;
          mdelay = 2 + random_bits(2);
          mstate = 1;
        end
        1: begin
          // Ready drops as the transfer starts
          if (mdelay <= 1) begin
            read_ctrl_ready = 1'b0;
            read_data_valid = 1'b1;
            read_data       = 64'(maddr);
            mstate          = 2;
          end else begin
            mdelay--;
          end
        end
        2: if (data_taken) begin
          mleft--;
          maddr = maddr + 32'd8;
          if (mleft == 0) begin
            read_data_valid = 1'b0;
            mstate          = 3;
          end else begin
            read_data = 64'(maddr);
          end
        end
        // One cycle after the last word so its TLAST is registered
        default: begin
          read_ctrl_ready = 1'b1;
          mstate          = 0;
        end
      endcase
    end
    out_ready = (random_bits(1) != 0);
  end

  task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
    @(posedge clk);
    #1;
    set = '{stb: 1'b1, addr: addr, data: data};
    @(posedge clk);
    #1;
    set.stb = 1'b0;
  endtask

  task automatic check_reg(input logic [7:0] addr, input logic [31:0] exp, input string name);
    @(posedge clk);
    #1;
    rb_addr = addr;
    #10;
    checker_i.compare_readback(name, exp);
  endtask

  task automatic wait_words(input int target, input int t);
    for (int n = 0; n < WORD_LIMIT && checker_i.received < target; n++) begin
      @(posedge clk);
    end
    if (checker_i.received < target) begin
      $display("timeout in test %0d, only %0d of %0d words arrived",
               t, checker_i.received, target);
      timeouts++;
    end
  endtask

  // ------------------------------------------------------------
  // Test sequence
  // ------------------------------------------------------------
  initial begin
    int          first;
    int          row;
    logic [31:0] base;
    logic [31:0] size;
    logic [31:0] max_len;
    set      = '0;
    rb_addr  = '0;
    rst      = 1'b1;
    timeouts = 0;
    $readmemh("bench/replay_play_tests.txt", tests);
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;
    for (int t = 0; t < NUM_TESTS; t++) begin
      row     = t * COLS;
      base    = tests[row];
      size    = tests[row+1];
      max_len = tests[row+2];
      checker_i.start_test(base, size, max_len);
      write_reg(`REPLAY_SR_PLAY_BASE_ADDR, base);
      write_reg(`REPLAY_SR_PLAY_BUFFER_SIZE, size);
      write_reg(`REPLAY_SR_MAXLEN, max_len);
      check_reg(`REPLAY_SR_PLAY_BASE_ADDR, base, "o_rb_data base");
      check_reg(`REPLAY_SR_PLAY_BUFFER_SIZE, size, "o_rb_data size");
      check_reg(`REPLAY_SR_MAXLEN, max_len, "o_rb_data maxlen");
      check_reg(8'h10, 32'h0, "o_rb_data unknown");
      first = 0;
      if (tests[row+3] != 0) begin
        // Reload loop halted once it has wrapped back to base
        checker_i.expect_cmd(tests[row+5], 8);
        write_reg(`REPLAY_SR_COMMAND, tests[row+5]);
        wait_words(24, t);
        write_reg(`REPLAY_SR_HALT, 32'h1);
        repeat (SETTLE) @(posedge clk);
        // Rest of the halted loop is no longer expected
        checker_i.start_test(base, size, max_len);
        first = 1;
      end
      for (int c = first; c < int'(tests[row+4]); c++) begin
        checker_i.expect_cmd(tests[row+5+c], 1);
        write_reg(`REPLAY_SR_COMMAND, tests[row+5+c]);
      end
      wait_words(int'(tests[row+9]), t);
      // Quiet time so extra words would show up
      repeat (SETTLE) @(posedge clk);
      checker_i.finish_test(int'(tests[row+9]));
      $display("test %0d finished: %0d words, %0d errors so far",
               t, checker_i.received, checker_i.errors);
    end
    $display("tests %0d, errors %0d, timeouts %0d", NUM_TESTS, checker_i.errors, timeouts);
    if (checker_i.errors == 0 && timeouts == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== bench/replay_play_props.sv ====
// Replay playback handshake assertions
// Stream stability, single cycle DMA request and reset state
`timescale 1ns/1ps
`default_nettype none

module replay_play_props import replay_pkg::*; (
  input wire        clk,
  input wire        rst,
  input wire beat_t o_out,
  input wire        o_out_valid,
  input wire        i_out_ready,
  input wire        o_read_ctrl_valid
);

  // Stalled beat holds until accepted
  a_out_stable: assert property (@(posedge clk) disable iff (rst)
    o_out_valid && !i_out_ready |=> o_out_valid && $stable(o_out))
    else $error("output beat changed while stalled");

  // Request valid is a one cycle pulse
  a_req_pulse: assert property (@(posedge clk) disable iff (rst)
    o_read_ctrl_valid |=> !o_read_ctrl_valid)
    else $error("read request valid held longer than one cycle");

  a_reset_low: assert property (@(posedge clk)
    rst |=> !o_read_ctrl_valid && !o_out_valid)
    else $error("valid high after reset");

endmodule

bind replay_play replay_play_props props_i (.*);

`default_nettype wire

// ==== bench/replay_play_checker.sv ====
// Replay playback checker
// Builds the expected stream from buffer rules and compares DUT beats and readback
`timescale 1ns/1ps
`default_nettype none
`include "replay_settings.svh"

module replay_play_checker import replay_pkg::*; (
  input wire        clk,
  input wire        rst,
  input wire beat_t i_out,
  input wire        i_out_valid,
  input wire        i_out_ready,
  input wire [31:0] i_rb_data
);

  // Expected beats with the address word in the low 64 bits and last on top
  logic [64:0] exp_q [$];
  logic [31:0] base;
  logic [31:0] size;
  logic [31:0] max_len;
  logic [31:0] cur_addr;
  int          size_words;
  int          avail;
  logic        chained;
  int          received;
  int          errors;

  initial begin
    received = 0;
    errors   = 0;
    chained  = 1'b0;
  end

  // Fresh buffer settings with the engine idle
  task automatic start_test(input logic [31:0] b, input logic [31:0] s, input logic [31:0] m);
    base       = b;
    size       = s;
    max_len    = m;
    size_words = int'(s >> 3);
    cur_addr   = b;
    avail      = size_words;
    chained    = 1'b0;
    received   = 0;
    exp_q.delete();
  endtask

  // Queue the words one command should produce
  // More than one repeat models a reload loop
  task automatic expect_cmd(input logic [31:0] cmd, input int repeats);
    int n;
    int b;
    if (!cmd[31] || cmd[28] || cmd[27:0] == 0 || size_words == 0) begin
      // Dropped command breaks any chain
      chained = 1'b0;
      return;
    end
    if (!chained) begin
      cur_addr = base;
      avail    = size_words;
    end
    for (int r = 0; r < repeats; r++) begin
      if (r > 0) begin
        cur_addr = base;
        avail    = size_words;
      end
      n = int'(cmd[27:0]);
      while (n > 0) begin
        b = `REPLAY_BURST_WORDS;
        if (avail < b) b = avail;
        if (n < b) b = n;
        // Packet count restarts with every burst
        for (int k = 0; k < b; k++) begin
          exp_q.push_back({(k == b - 1) || ((k + 1) % max_len == 0),
                           64'(cur_addr + 32'(k * 8))});
        end
        cur_addr = cur_addr + 32'(b * 8);
        avail    = avail - b;
        n        = n - b;
        if (cur_addr >= base + size) begin
          cur_addr = base;
          avail    = size_words;
        end
      end
    end
    chained = cmd[30];
  endtask

  task automatic compare_readback(input string name, input logic [31:0] exp);
    if (i_rb_data !== exp) begin
      $display("FAIL t=%0t %s got %h exp %h", $time, name, i_rb_data, exp);
      errors++;
    end
  endtask

  task automatic finish_test(input int exp_words);
    if (received != exp_words) begin
      $display("FAIL t=%0t word_count got %0d exp %0d", $time, received, exp_words);
      errors++;
    end
    if (exp_q.size() != 0) begin
      $display("stream ended with %0d expected words never seen", exp_q.size());
      errors++;
    end
  endtask

  // Negedge view equals the handshake taken at the next rising edge
  always @(negedge clk) begin
    logic [64:0] e;
    if (!rst && i_out_valid && i_out_ready) begin
      received++;
      if (exp_q.size() == 0) begin
        $display("unexpected extra word %h at t=%0t", i_out.data, $time);
        errors++;
      end else begin
        e = exp_q.pop_front();
        if (i_out.data !== e[63:0]) begin
          $display("FAIL t=%0t o_out.data got %h exp %h", $time, i_out.data, e[63:0]);
          errors++;
        end
        if (i_out.last !== e[64]) begin
          $display("FAIL t=%0t o_out.last got %b exp %b", $time, i_out.last, e[64]);
          errors++;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/replay_play.sv ====
// Replay playback top
// Settings bus, command queue, playback engine, TLAST and output FIFO
`timescale 1ns/1ps
`default_nettype none
`include "replay_settings.svh"

module replay_play import replay_pkg::*; (
  input  wire                             clk,
  input  wire                             rst,
  input  wire  set_bus_t                  i_set,
  input  wire  [7:0]                      i_rb_addr,
  output logic [31:0]                     o_rb_data,
  output dma_req_t                        o_read_req,
  output logic                            o_read_ctrl_valid,
  input  wire                             i_read_ctrl_ready,
  input  wire  [`REPLAY_DATA_WIDTH-1:0]   i_read_data,
  input  wire                             i_read_data_valid,
  output logic                            o_read_data_ready,
  output beat_t                           o_out,
  output logic                            o_out_valid,
  input  wire                             i_out_ready
);

  logic                             halt;
  logic                             halt_clear;
  logic [`REPLAY_ADDR_WIDTH-1:0]    base_addr;
  logic [`REPLAY_ADDR_WIDTH-1:0]    buffer_size;
  logic [`REPLAY_COUNT_WIDTH:0]     max_len;
  play_cmd_t                        reg_cmd;
  logic                             reg_cmd_valid;
  play_cmd_t                        q_cmd;
  logic                             q_cmd_valid;
  logic                             q_cmd_ready;
  logic [`REPLAY_OUT_FIFO_LOG2:0]   fifo_space;
  beat_t                            read_beat;

  replay_regs regs_i (
    .clk, .rst, .i_set, .i_rb_addr, .o_rb_data,
    .i_halt_clear (halt_clear), .o_halt (halt),
    .o_base_addr (base_addr), .o_buffer_size (buffer_size), .o_max_len (max_len),
    .o_cmd (reg_cmd), .o_cmd_valid (reg_cmd_valid)
  );

  // Halt acknowledge also flushes queued commands
  replay_cmd_fifo cmd_fifo_i (
    .clk, .rst, .i_clear (halt_clear),
    .i_cmd (reg_cmd), .i_cmd_valid (reg_cmd_valid),
    .o_cmd (q_cmd), .o_cmd_valid (q_cmd_valid), .i_cmd_ready (q_cmd_ready)
  );

  replay_play_fsm play_fsm_i (
    .clk, .rst, .i_base_addr (base_addr), .i_buffer_size (buffer_size),
    .i_cmd (q_cmd), .i_cmd_valid (q_cmd_valid), .o_cmd_ready (q_cmd_ready),
    .i_halt (halt), .o_halt_clear (halt_clear), .i_fifo_space (fifo_space),
    .o_read_req, .o_read_ctrl_valid, .i_read_ctrl_ready
  );

  replay_tlast_gen tlast_gen_i (
    .clk, .rst, .i_read_req (o_read_req), .i_read_ctrl_valid (o_read_ctrl_valid),
    .i_read_ctrl_ready, .i_max_len (max_len), .i_read_data, .i_read_data_valid,
    .i_read_data_ready (o_read_data_ready), .o_beat (read_beat)
  );

  // FIFO ready doubles as DMA data ready
  replay_out_fifo out_fifo_i (
    .clk, .rst, .i_beat (read_beat), .i_valid (i_read_data_valid),
    .o_ready (o_read_data_ready), .o_beat (o_out), .o_valid (o_out_valid),
    .i_ready (i_out_ready), .o_space (fifo_space)
  );

endmodule

`default_nettype wire

// ==== source/replay_out_fifo.sv ====
// Replay output FIFO
// Buffers stream beats read from memory and reports free entries
`timescale 1ns/1ps
`default_nettype none
`include "replay_settings.svh"

module replay_out_fifo import replay_pkg::*; (
  input  wire                              clk,
  input  wire                              rst,
  input  wire  beat_t                      i_beat,
  input  wire                              i_valid,
  output logic                             o_ready,
  output beat_t                            o_beat,
  output logic                             o_valid,
  input  wire                              i_ready,
  output logic [`REPLAY_OUT_FIFO_LOG2:0]   o_space
);

  localparam int LOG2 = `REPLAY_OUT_FIFO_LOG2;

  beat_t           mem [2**LOG2];
  logic [LOG2-1:0] wr_ptr;
  logic [LOG2-1:0] rd_ptr;
  logic [LOG2:0]   count;
  logic            push;
  logic            pop;

  // Full when the top count bit is set
  assign o_ready = !count[LOG2];
  assign o_valid = (count != '0);
  assign o_beat  = mem[rd_ptr];
  assign o_space = (LOG2+1)'(2**LOG2) - count;
  assign push    = i_valid && o_ready;
  assign pop     = o_valid && i_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop)  rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= i_beat;
    end
  end

endmodule

`default_nettype wire

// ==== source/replay_tlast_gen.sv ====
// Replay packet boundary generator
// Flags the last word of each DMA burst and of each max length packet
`timescale 1ns/1ps
`default_nettype none
`include "replay_settings.svh"

module replay_tlast_gen import replay_pkg::*; (
  input  wire                             clk,
  input  wire                             rst,
  input  wire  dma_req_t                  i_read_req,
  input  wire                             i_read_ctrl_valid,
  input  wire                             i_read_ctrl_ready,
  input  wire  [`REPLAY_COUNT_WIDTH:0]    i_max_len,
  input  wire  [`REPLAY_DATA_WIDTH-1:0]   i_read_data,
  input  wire                             i_read_data_valid,
  input  wire                             i_read_data_ready,
  output beat_t                           o_beat
);

  localparam int CW = `REPLAY_COUNT_WIDTH;

  logic [CW-1:0] burst_left;   // Words after the current one in this burst
  logic [CW:0]   pkt_count;    // Words already sent in this packet
  logic [CW:0]   pkt_next;
  logic          last;
  logic          accept;

  assign accept   = i_read_data_valid && i_read_data_ready;
  assign pkt_next = pkt_count + 1'b1;

  // Burst end or packet reaching max length
  assign last   = (burst_left == '0) || (pkt_next == i_max_len);
  assign o_beat = '{data: i_read_data, last: last};

  // Memory side holds ctrl ready low until the whole burst is in,
  // so a new request never overlaps the words of the previous one
  always_ff @(posedge clk) begin
    if (rst) begin
      burst_left <= '0;
      pkt_count  <= '0;
    end else if (i_read_ctrl_valid && i_read_ctrl_ready) begin
      burst_left <= i_read_req.count;
      pkt_count  <= '0;
    end else if (accept) begin
      burst_left <= burst_left - 1'b1;
      pkt_count  <= last ? '0 : pkt_next;
    end
  end

endmodule

`default_nettype wire

// ==== source/replay_play_fsm.sv ====
// Replay playback engine
// Turns queued commands into DMA read bursts with buffer wrap, chain and reload
`timescale 1ns/1ps
`default_nettype none
`include "replay_settings.svh"

module replay_play_fsm import replay_pkg::*; (
  input  wire                             clk,
  input  wire                             rst,
  input  wire  [`REPLAY_ADDR_WIDTH-1:0]   i_base_addr,
  input  wire  [`REPLAY_ADDR_WIDTH-1:0]   i_buffer_size,
  input  wire  play_cmd_t                 i_cmd,
  input  wire                             i_cmd_valid,
  output logic                            o_cmd_ready,
  input  wire                             i_halt,
  output logic                            o_halt_clear,
  input  wire  [`REPLAY_OUT_FIFO_LOG2:0]  i_fifo_space,
  output dma_req_t                        o_read_req,
  output logic                            o_read_ctrl_valid,
  input  wire                             i_read_ctrl_ready
);

  localparam int          AW         = `REPLAY_ADDR_WIDTH;
  localparam int          LW         = `REPLAY_LINES_WIDTH;
  localparam int          CW         = `REPLAY_COUNT_WIDTH;
  localparam int          WORD_SHIFT = $clog2(`REPLAY_WORD_BYTES);
  localparam logic [CW:0] BURST      = (CW+1)'(`REPLAY_BURST_WORDS);

  typedef enum logic [2:0] {
    S_IDLE, S_WAIT_SPACE, S_SIZE_CALC, S_REQ, S_WAIT_START, S_WAIT_COMMIT, S_DONE_CHECK
  } state_t;

  state_t        state;
  // Buffer geometry frozen when a command starts
  logic [AW-1:0] base_addr;
  logic [AW-1:0] buffer_end;
  logic [AW-1:0] size_words;
  // Walking position and what is left before the wrap
  logic [AW-1:0] play_addr;
  logic [AW-1:0] next_addr;
  logic [AW-1:0] words_avail;
  // Active command
  logic [LW-1:0] words_left;
  logic [LW-1:0] cmd_lines;
  logic          cmd_chain;
  logic          cmd_reload;
  // Burst sizing pipeline
  logic [CW:0]   max_dma;
  logic [CW:0]   req_words;
  logic [CW:0]   req_words_m1;
  logic          cmd_playable;
  logic          chain_next;

  // Stop, zero length and non immediate commands are dequeued and dropped
  assign cmd_playable = i_cmd.send_imm && !i_cmd.stop && (i_cmd.num_lines != '0);
  assign req_words_m1 = req_words - 1'b1;

  // Halt is taken only between bursts
  assign o_halt_clear = i_halt &&
    (state == S_IDLE || state == S_WAIT_SPACE || state == S_DONE_CHECK);
  assign chain_next   = (state == S_DONE_CHECK) && (words_left == '0) && cmd_chain;
  assign o_cmd_ready  = i_cmd_valid && !o_halt_clear && (state == S_IDLE || chain_next);

  //------------------------------------------------------------
  // State and request valid
  //------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      state             <= S_IDLE;
      o_read_ctrl_valid <= 1'b0;
    end else begin
      o_read_ctrl_valid <= 1'b0;
      case (state)
        S_IDLE: begin
          // Empty buffer means nothing to play
          if (o_cmd_ready && cmd_playable && (i_buffer_size[AW-1:WORD_SHIFT] != '0)) begin
            state <= S_WAIT_SPACE;
          end
        end
        S_WAIT_SPACE: begin
          // Room for a full burst before asking
          if (o_halt_clear) begin
            state <= S_IDLE;
          end else if (i_fifo_space >= `REPLAY_BURST_WORDS) begin
            state <= S_SIZE_CALC;
          end
        end
        S_SIZE_CALC: state <= S_REQ;
        S_REQ: begin
          if (i_read_ctrl_ready) begin
            o_read_ctrl_valid <= 1'b1;
            state             <= S_WAIT_START;
          end
        end
        // Ready low means the transfer started
        S_WAIT_START:  if (!i_read_ctrl_ready) state <= S_WAIT_COMMIT;
        // Ready back high after the last word
        S_WAIT_COMMIT: if (i_read_ctrl_ready) state <= S_DONE_CHECK;
        S_DONE_CHECK: begin
          if (o_halt_clear) begin
            state <= S_IDLE;
          end else if (words_left != '0) begin
            state <= S_WAIT_SPACE;
          end else if (o_cmd_ready) begin
            state <= cmd_playable ? S_WAIT_SPACE : S_IDLE;
          end else if (cmd_chain && cmd_reload) begin
            state <= S_WAIT_SPACE;
          end else if (!cmd_chain) begin
            state <= S_IDLE;
          end
          // Chained with empty queue, wait here for the next command
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  //------------------------------------------------------------
  // Address, counts and request payload
  //------------------------------------------------------------
  always_ff @(posedge clk) begin
    case (state)
      S_IDLE: begin
        base_addr   <= i_base_addr;
        buffer_end  <= i_base_addr + i_buffer_size;
        size_words  <= i_buffer_size >> WORD_SHIFT;
        words_avail <= i_buffer_size >> WORD_SHIFT;
        play_addr   <= i_base_addr;
        words_left  <= i_cmd.num_lines;
        cmd_lines   <= i_cmd.num_lines;
        cmd_chain   <= i_cmd.chain;
        cmd_reload  <= i_cmd.reload;
      end
      S_WAIT_SPACE: max_dma <= (words_avail >= AW'(BURST)) ? BURST : words_avail[CW:0];
      S_SIZE_CALC:  req_words <= (words_left >= LW'(max_dma)) ? max_dma : words_left[CW:0];
      S_REQ: begin
        o_read_req.addr  <= play_addr;
        o_read_req.count <= req_words_m1[CW-1:0];
      end
      S_WAIT_START: begin
        if (!i_read_ctrl_ready) begin
          next_addr   <= play_addr + (AW'(req_words) << WORD_SHIFT);
          words_left  <= words_left - LW'(req_words);
          words_avail <= words_avail - AW'(req_words);
        end
      end
      S_WAIT_COMMIT: begin
        // Wrap to the base at the buffer end
        if (i_read_ctrl_ready) begin
          if (next_addr >= buffer_end) begin
            play_addr   <= base_addr;
            words_avail <= size_words;
          end else begin
            play_addr <= next_addr;
          end
        end
      end
      S_DONE_CHECK: begin
        if (words_left == '0) begin
          if (o_cmd_ready) begin
            // Chained command keeps the address
            words_left <= i_cmd.num_lines;
            cmd_lines  <= i_cmd.num_lines;
            cmd_chain  <= i_cmd.chain;
            cmd_reload <= i_cmd.reload;
          end else if (cmd_chain && cmd_reload) begin
            // Reload starts over at the buffer base
            words_left  <= cmd_lines;
            play_addr   <= base_addr;
            words_avail <= size_words;
          end
        end
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// ==== source/replay_cmd_fifo.sv ====
// Replay command queue
// Short register FIFO of playback commands, flushed on halt
`timescale 1ns/1ps
`default_nettype none
`include "replay_settings.svh"

module replay_cmd_fifo import replay_pkg::*; (
  input  wire             clk,
  input  wire             rst,
  input  wire             i_clear,
  input  wire  play_cmd_t i_cmd,
  input  wire             i_cmd_valid,
  output play_cmd_t       o_cmd,
  output logic            o_cmd_valid,
  input  wire             i_cmd_ready
);

  localparam int LOG2 = `REPLAY_CMD_FIFO_LOG2;

  play_cmd_t       mem [2**LOG2];
  logic [LOG2-1:0] wr_ptr;
  logic [LOG2-1:0] rd_ptr;
  logic [LOG2:0]   count;
  logic            push;
  logic            pop;

  // Top count bit set means full, writes then get dropped
  assign push        = i_cmd_valid && !count[LOG2];
  assign pop         = i_cmd_ready && o_cmd_valid;
  assign o_cmd_valid = (count != '0);
  assign o_cmd       = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (rst || i_clear) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop)  rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= i_cmd;
    end
  end

endmodule

`default_nettype wire

// ==== source/replay_regs.sv ====
// Replay settings registers
// Base, size and max length registers, halt flag, command push and readback
`timescale 1ns/1ps
`default_nettype none
`include "replay_settings.svh"

module replay_regs import replay_pkg::*; (
  input  wire                             clk,
  input  wire                             rst,
  input  wire  set_bus_t                  i_set,
  input  wire  [7:0]                      i_rb_addr,
  output logic [31:0]                     o_rb_data,
  input  wire                             i_halt_clear,
  output logic                            o_halt,
  output logic [`REPLAY_ADDR_WIDTH-1:0]   o_base_addr,
  output logic [`REPLAY_ADDR_WIDTH-1:0]   o_buffer_size,
  output logic [`REPLAY_COUNT_WIDTH:0]    o_max_len,
  output play_cmd_t                       o_cmd,
  output logic                            o_cmd_valid
);

  logic cmd_wr;
  logic halt_wr;

  assign cmd_wr  = i_set.stb && (i_set.addr == `REPLAY_SR_COMMAND);
  assign halt_wr = i_set.stb && (i_set.addr == `REPLAY_SR_HALT);

  always_ff @(posedge clk) begin
    if (rst) begin
      o_base_addr   <= '0;
      o_buffer_size <= '0;
      o_max_len     <= (`REPLAY_COUNT_WIDTH+1)'(`REPLAY_BURST_WORDS);
      o_halt        <= 1'b0;
      o_cmd_valid   <= 1'b0;
    end else begin
      // One cycle push into the command queue
      o_cmd_valid <= cmd_wr;
      if (i_set.stb) begin
        case (i_set.addr)
          `REPLAY_SR_PLAY_BASE_ADDR:   o_base_addr   <= i_set.data[`REPLAY_ADDR_WIDTH-1:0];
          `REPLAY_SR_PLAY_BUFFER_SIZE: o_buffer_size <= i_set.data[`REPLAY_ADDR_WIDTH-1:0];
          `REPLAY_SR_MAXLEN:           o_max_len     <= i_set.data[`REPLAY_COUNT_WIDTH:0];
          default: ;
        endcase
      end
      // Halt holds until the engine acknowledges it, a new write wins
      if (halt_wr) begin
        o_halt <= 1'b1;
      end else if (i_halt_clear) begin
        o_halt <= 1'b0;
      end
    end
  end

  // Command word only matters alongside o_cmd_valid
  always_ff @(posedge clk) begin
    if (cmd_wr) begin
      o_cmd <= play_cmd_t'(i_set.data);
    end
  end

  // Readback, unknown offsets return zero
  always_comb begin
    case (i_rb_addr)
      `REPLAY_SR_PLAY_BASE_ADDR:   o_rb_data = 32'(o_base_addr);
      `REPLAY_SR_PLAY_BUFFER_SIZE: o_rb_data = 32'(o_buffer_size);
      `REPLAY_SR_MAXLEN:           o_rb_data = 32'(o_max_len);
      default:                     o_rb_data = 32'h0;
    endcase
  end

endmodule

`default_nettype wire

// ==== source/replay_pkg.sv ====
// Replay playback types
// Command word, settings write, DMA read request and stream beat
`default_nettype none
`include "replay_settings.svh"

package replay_pkg;

  // Playback command, send_imm in bit 31
  typedef struct packed {
    logic                            send_imm;
    logic                            chain;   // Run next command when done
    logic                            reload;  // Repeat if chained and queue empty
    logic                            stop;
    logic [`REPLAY_LINES_WIDTH-1:0]  num_lines;
  } play_cmd_t;

  // One settings bus write, single cycle
  typedef struct packed {
    logic        stb;
    logic [7:0]  addr;
    logic [31:0] data;
  } set_bus_t;

  // DMA read request, byte address and words minus one
  typedef struct packed {
    logic [`REPLAY_ADDR_WIDTH-1:0]  addr;
    logic [`REPLAY_COUNT_WIDTH-1:0] count;
  } dma_req_t;

  // Output stream word with packet end flag
  typedef struct packed {
    logic [`REPLAY_DATA_WIDTH-1:0] data;
    logic                          last;
  } beat_t;

endpackage

`default_nettype wire

// ==== source/replay_settings.svh ====
// Replay playback settings
// Widths, burst size, queue depths and settings bus register offsets
`ifndef REPLAY_SETTINGS_SVH
`define REPLAY_SETTINGS_SVH

// Stream and memory geometry
`define REPLAY_DATA_WIDTH    64
`define REPLAY_ADDR_WIDTH    32
`define REPLAY_WORD_BYTES    8
`define REPLAY_LINES_WIDTH   28

// DMA count field carries words minus one
`define REPLAY_COUNT_WIDTH   4
`define REPLAY_BURST_WORDS   16

// Queue depths as powers of two
`define REPLAY_OUT_FIFO_LOG2 5
`define REPLAY_CMD_FIFO_LOG2 2

// Settings bus offsets
`define REPLAY_SR_PLAY_BASE_ADDR   8'd132
`define REPLAY_SR_PLAY_BUFFER_SIZE 8'd133
`define REPLAY_SR_COMMAND          8'd152
`define REPLAY_SR_HALT             8'd155
`define REPLAY_SR_MAXLEN           8'd156

`endif
